/* all.f */
hdl/lsu_pkg.sv
hdl/agu.sv
hdl/dmem_extender.sv
hdl/loadstore_unit.sv
hdl/lsu_top.sv
tests/tb_dmem.sv
tests/tb_lsu.sv

/* run.sh */
#!/bin/sh
# build and run the load/store unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f all.f --top-module tb_lsu \
  --Mdir obj_dir -o tb_lsu > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/tb_lsu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Verification passed$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* tests/tb_lsu.sv */
// tb_lsu: testbench driving a table of loads and stores through the load/store unit
`timescale 1ns/100ps
`default_nettype none

module tb_lsu;

  // one table row with expectations filled in when the row is built
  typedef struct packed {
    logic                      st;        // store when set
    lsu_pkg::load_t            lt;
    logic [lsu_pkg::XLEN-1:0]  base;
    logic [lsu_pkg::XLEN-1:0]  off;
    logic [lsu_pkg::XLEN-1:0]  sdata;
    logic [lsu_pkg::REG_W-1:0] rd;
    logic [lsu_pkg::TAG_W-1:0] tag;
    logic                      fl;        // flush right after acceptance
    logic                      exp_mal;
    logic [lsu_pkg::XLEN-1:0]  exp_data;
  } entry_t;

  logic                     CLK;
  logic                     nRST;
  logic                     flush;
  lsu_pkg::ls_req_t         req;
  logic                     busy;
  lsu_pkg::ls_resp_t        resp;
  lsu_pkg::dbus_req_t       dbus;
  logic [lsu_pkg::XLEN-1:0] dbus_rdata;
  logic                     dbus_busy;

  entry_t      tbl[$];
  entry_t      exp_q[$];      // accepted, completion outstanding
  logic [31:0] shadow [256];  // reference memory contents

  lsu_top i_lsu_top (.*);
  tb_dmem i_tb_dmem (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  function automatic logic [31:0] init_word(input logic [7:0] i);
    init_word = {i ^ 8'h96, i + 8'h4b, ~i, i ^ 8'h3c};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      abort_run($sformatf("ERROR %s: actual 0x%08h expected 0x%08h", name, act, exp));
    end
  endtask

  // derive misalignment and load data from the shadow and apply stores to it
  task automatic add_entry(input logic st, input lsu_pkg::load_t lt, input logic [31:0] base,
                           input logic [31:0] off, input logic [31:0] sdata, input logic fl);
    entry_t      e;
    logic [31:0] a;
    logic [31:0] w;
    logic [7:0]  b;
    logic [15:0] h;
    a = base + off;
    w = shadow[a[9:2]];
    b = w[{a[1:0], 3'b000} +: 8];
    h = w[{a[1], 4'b0000} +: 16];
    e = '{st: st, lt: lt, base: base, off: off, sdata: sdata, rd: 5'(tbl.size() + 7),
          tag: 3'(tbl.size()), fl: fl, exp_mal: 1'b0, exp_data: 32'h0};
    if (lt == lsu_pkg::lh || lt == lsu_pkg::lhu) e.exp_mal = a[0];
    else if (lt == lsu_pkg::lw) e.exp_mal = |a[1:0];
    if (!st && !e.exp_mal) begin
      case (lt)
        lsu_pkg::lb:  e.exp_data = {{24{b[7]}}, b};
        lsu_pkg::lbu: e.exp_data = {24'h0, b};
        lsu_pkg::lh:  e.exp_data = {{16{h[15]}}, h};
        lsu_pkg::lhu: e.exp_data = {16'h0, h};
        default:      e.exp_data = w;
      endcase
    end
    if (st && !e.exp_mal && !fl) begin  // only lanes of the store size change
      if (lt == lsu_pkg::lb || lt == lsu_pkg::lbu) w[{a[1:0], 3'b000} +: 8] = sdata[7:0];
      else if (lt == lsu_pkg::lh || lt == lsu_pkg::lhu) w[{a[1], 4'b0000} +: 16] = sdata[15:0];
      else w = sdata;
      shadow[a[9:2]] = w;
    end
    tbl.push_back(e);
  endtask

  task automatic build_table();
    for (int k = 0; k < 256; k++) shadow[k] = init_word(8'(k));
    add_entry(1'b0, lsu_pkg::lw, 32'h100, 32'h10, 32'h0, 1'b0);
    add_entry(1'b0, lsu_pkg::lw, 32'h220, 32'hffff_fff0, 32'h0, 1'b0);  // negative offset
    for (int k = 0; k < 4; k++) begin
      add_entry(1'b0, lsu_pkg::lb, 32'h120, 32'(k), 32'h0, 1'b0);
      add_entry(1'b0, lsu_pkg::lbu, 32'h120, 32'(k), 32'h0, 1'b0);
    end
    for (int k = 0; k < 4; k += 2) begin
      add_entry(1'b0, lsu_pkg::lh, 32'h130, 32'(k), 32'h0, 1'b0);
      add_entry(1'b0, lsu_pkg::lhu, 32'h130, 32'(k), 32'h0, 1'b0);
    end
    add_entry(1'b1, lsu_pkg::lb, 32'h140, 32'h1, 32'h0000_00a5, 1'b0);
    add_entry(1'b1, lsu_pkg::lb, 32'h140, 32'h3, 32'h1111_115a, 1'b0);
    add_entry(1'b0, lsu_pkg::lw, 32'h140, 32'h0, 32'h0, 1'b0);
    add_entry(1'b1, lsu_pkg::lh, 32'h150, 32'h2, 32'h1234_abcd, 1'b0);
    add_entry(1'b0, lsu_pkg::lw, 32'h150, 32'h0, 32'h0, 1'b0);
    add_entry(1'b1, lsu_pkg::lh, 32'h154, 32'h0, 32'h0000_7e11, 1'b0);
    add_entry(1'b0, lsu_pkg::lw, 32'h154, 32'h0, 32'h0, 1'b0);
    add_entry(1'b1, lsu_pkg::lw, 32'h160, 32'h0, 32'hdead_beef, 1'b0);
    add_entry(1'b0, lsu_pkg::lw, 32'h160, 32'h0, 32'h0, 1'b0);
    // misaligned accesses leave memory as it was
    add_entry(1'b0, lsu_pkg::lh, 32'h170, 32'h1, 32'h0, 1'b0);
    add_entry(1'b0, lsu_pkg::lhu, 32'h170, 32'h3, 32'h0, 1'b0);
    add_entry(1'b0, lsu_pkg::lw, 32'h170, 32'h2, 32'h0, 1'b0);
    add_entry(1'b1, lsu_pkg::lw, 32'h180, 32'h1, 32'hffff_ffff, 1'b0);
    add_entry(1'b1, lsu_pkg::lh, 32'h180, 32'h3, 32'h0000_ffff, 1'b0);
    add_entry(1'b0, lsu_pkg::lw, 32'h180, 32'h0, 32'h0, 1'b0);
    add_entry(1'b1, lsu_pkg::lw, 32'h190, 32'h0, 32'h0bad_f00d, 1'b1);  // flushed store
    add_entry(1'b0, lsu_pkg::lw, 32'h190, 32'h0, 32'h0, 1'b1);
    add_entry(1'b0, lsu_pkg::lw, 32'h190, 32'h0, 32'h0, 1'b0);
    for (int k = 0; k < 12; k++) begin  // back to back under random latency
      add_entry(1'b1, lsu_pkg::lb, 32'h1a0, 32'(k), 32'(k * 37 + 5), 1'b0);
      add_entry(1'b0, lsu_pkg::lw, 32'h1a0, 32'(k & ~3), 32'h0, 1'b0);
    end
  endtask

  // returns on the rising edge that takes the request
  task automatic wait_accept();
    int cyc;
    cyc = 0;
    @(negedge CLK);
    while (busy) begin
      cyc++;
      if (cyc > 50) abort_run("timeout: request was never accepted");
      @(negedge CLK);
    end
    @(posedge CLK);
  endtask

  // completion monitor where every done must match the oldest accepted row
  initial begin
    entry_t e;
    forever begin
      @(negedge CLK);
      if (nRST && resp.done) begin
        if (exp_q.size() == 0) abort_run("completion seen with no access outstanding");
        e = exp_q.pop_front();
        check("resp.tag", 32'(resp.tag), 32'(e.tag));
        check("resp.reg_rd", 32'(resp.reg_rd), 32'(e.rd));
        check("resp.wen", 32'(resp.wen), 32'(!e.st && !e.exp_mal));
        check("resp.mal_addr", 32'(resp.mal_addr), 32'(e.exp_mal));
        check("resp.addr", resp.addr, e.base + e.off);
        check("resp.wdata", resp.wdata, e.exp_data);
        check("dbus.ren", 32'(dbus.ren), 32'(!e.st && !e.exp_mal));  // no bus when misaligned
        check("dbus.wen", 32'(dbus.wen), 32'(e.st && !e.exp_mal));
      end
    end
  end

  initial begin
    int cyc;
    nRST  = 1'b0;
    flush = 1'b0;
    req   = '0;
    build_table();
    repeat (2) @(posedge CLK);
    #1 nRST = 1'b1;
    @(negedge CLK);
    check("busy", 32'(busy), 32'h0);
    check("resp.done", 32'(resp.done), 32'h0);
    check("dbus.ren", 32'(dbus.ren), 32'h0);
    check("dbus.wen", 32'(dbus.wen), 32'h0);
    @(posedge CLK);
    #1;
    for (int n = 0; n < tbl.size(); n++) begin
      req.valid      = 1'b1;           // stays high across rows
      req.dren       = !tbl[n].st;
      req.dwen       = tbl[n].st;
      req.wen        = !tbl[n].st;
      req.reg_rd     = tbl[n].rd;
      req.load_type  = tbl[n].lt;
      req.port_a     = tbl[n].base;
      req.port_b     = tbl[n].off;
      req.store_data = tbl[n].sdata;
      req.tag        = tbl[n].tag;
      wait_accept();
      #1;
      if (tbl[n].fl) begin
        req.valid = 1'b0;
        flush     = 1'b1;              // kill it in its first latch cycle
        @(posedge CLK);
        #1 flush = 1'b0;
      end else begin
        exp_q.push_back(tbl[n]);
      end
    end
    req.valid = 1'b0;
    cyc = 0;
    while (exp_q.size() != 0) begin
      @(posedge CLK);
      cyc++;
      if (cyc > 100) abort_run("timeout: completions missing after the last request");
    end
    repeat (4) @(posedge CLK);         // room for a stray done
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/tb_dmem.sv */
// tb_dmem: behavioral data memory with random busy latency on the simple bus
`timescale 1ns/100ps
`default_nettype none

module tb_dmem (
  input  wire logic                     CLK,
  input  wire logic                     nRST,
  input  wire lsu_pkg::dbus_req_t       dbus,
  output logic      [lsu_pkg::XLEN-1:0] dbus_rdata,
  output logic                          dbus_busy
);

  logic [31:0] mem [256];
  logic [31:0] merged;    // current word with the enabled lanes replaced
  logic [7:0]  lfsr_q;
  logic [7:0]  lfsr_1;
  logic [7:0]  lfsr_2;
  logic [1:0]  next_lat;  // wait cycles for the next access
  logic [1:0]  cnt;
  logic        active;
  logic        req_on;

  // fill word from the whole word index
  function automatic logic [31:0] init_word(input logic [7:0] i);
    init_word = {i ^ 8'h96, i + 8'h4b, ~i, i ^ 8'h3c};
  endfunction

  // 8-bit Fibonacci LFSR, taps 8 6 5 4
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    lfsr_step = {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  assign lfsr_1     = lfsr_step(lfsr_q);
  assign lfsr_2     = lfsr_step(lfsr_1);  // one step per latency bit
  assign req_on     = dbus.ren | dbus.wen;
  assign dbus_busy  = req_on & (active ? (cnt != 2'd0) : (next_lat != 2'd0));
  assign dbus_rdata = mem[dbus.addr[9:2]];

  always_comb begin
    merged = mem[dbus.addr[9:2]];
    for (int j = 0; j < 4; j++) begin
      if (dbus.byte_en[j]) merged[j*8 +: 8] = dbus.wdata[j*8 +: 8];
    end
  end

  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      active   <= 1'b0;
      cnt      <= 2'd0;
      next_lat <= 2'd0;
      lfsr_q   <= 8'd39;                      // seed
      for (int k = 0; k < 256; k++) mem[k] <= init_word(8'(k));
    end else if (req_on && !dbus_busy) begin  // completing cycle
      if (dbus.wen) mem[dbus.addr[9:2]] <= merged;
      active   <= 1'b0;
      lfsr_q   <= lfsr_2;
      next_lat <= {lfsr_1[0], lfsr_2[0]};
    end else if (req_on) begin
      active <= 1'b1;
      cnt    <= active ? cnt - 2'd1 : next_lat - 2'd1;
    end else begin
      active <= 1'b0;                         // abandoned by a flush
    end
  end

endmodule

`default_nettype wire

/* hdl/lsu_top.sv */
// lsu_top: load/store subsystem joining address unit, latch control and extender
`timescale 1ns/100ps
`default_nettype none

module lsu_top (
  input  wire logic                     CLK,
  input  wire logic                     nRST,
  input  wire logic                     flush,       // hazard flush, halt included
  input  wire lsu_pkg::ls_req_t         req,
  input  wire logic [lsu_pkg::XLEN-1:0] dbus_rdata,
  input  wire logic                     dbus_busy,
  output logic                          busy,        // back-pressure to issue
  output lsu_pkg::ls_resp_t             resp,
  output lsu_pkg::dbus_req_t            dbus
);

  logic [lsu_pkg::XLEN-1:0] agu_addr;
  logic [3:0]               agu_byte_en;
  logic                     agu_mal;
  logic [lsu_pkg::XLEN-1:0] ext_data;
  lsu_pkg::load_t           lat_load_type;
  logic [3:0]               lat_byte_en;

  // address from the issuing request, before the latch
  agu i_agu (
    .port_a    (req.port_a),
    .port_b    (req.port_b),
    .load_type (req.load_type),
    .address   (agu_addr),
    .byte_en   (agu_byte_en),
    .mal_addr  (agu_mal)
  );

  // extension works on the latched access
  dmem_extender i_dmem_extender (
    .dmem_in   (dbus_rdata),
    .load_type (lat_load_type),
    .byte_en   (lat_byte_en),
    .ext_out   (ext_data)
  );

  loadstore_unit i_loadstore_unit (
    .CLK           (CLK),
    .nRST          (nRST),
    .flush         (flush),
    .req           (req),
    .address       (agu_addr),
    .byte_en       (agu_byte_en),
    .mal_addr      (agu_mal),
    .dbus_busy     (dbus_busy),
    .ext_data      (ext_data),
    .busy          (busy),
    .resp          (resp),
    .dbus          (dbus),
    .lat_load_type (lat_load_type),
    .lat_byte_en   (lat_byte_en)
  );

endmodule

`default_nettype wire

/* hdl/loadstore_unit.sv */
// loadstore_unit: one-entry memory latch driving the data bus and reporting completion
`timescale 1ns/100ps
`default_nettype none

module loadstore_unit (
  input  wire logic                     CLK,
  input  wire logic                     nRST,
  input  wire logic                     flush,
  input  wire lsu_pkg::ls_req_t         req,
  input  wire logic [lsu_pkg::XLEN-1:0] address,      // from agu
  input  wire logic [3:0]               byte_en,
  input  wire logic                     mal_addr,
  input  wire logic                     dbus_busy,
  input  wire logic [lsu_pkg::XLEN-1:0] ext_data,     // extended read data
  output logic                          busy,
  output lsu_pkg::ls_resp_t             resp,
  output lsu_pkg::dbus_req_t            dbus,
  output lsu_pkg::load_t                lat_load_type,
  output logic      [3:0]               lat_byte_en
);

  lsu_pkg::lsu_state_t state;

  // latched access fields
  logic                      dren_q;
  logic                      dwen_q;
  logic                      wen_q;
  logic [lsu_pkg::REG_W-1:0] reg_rd_q;
  lsu_pkg::load_t            load_type_q;
  logic [lsu_pkg::XLEN-1:0]  store_data_q;
  logic [lsu_pkg::TAG_W-1:0] tag_q;
  logic [lsu_pkg::XLEN-1:0]  address_q;
  logic [3:0]                byte_en_q;
  logic                      mal_q;

  logic full;
  logic bus_act;    // latched access really goes to the bus
  logic complete;
  logic accept;

  assign full     = (state == lsu_pkg::ls_busy);
  assign bus_act  = (dren_q | dwen_q) & ~mal_q;
  // misaligned or bus-less entries finish in their first latch cycle
  assign complete = full & ~(bus_act & dbus_busy);
  assign busy     = full & ~complete;
  // a flush also squashes whatever sits at issue
  assign accept   = req.valid & ~busy & ~flush;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= lsu_pkg::ls_idle;
    end else if (flush) begin
      state <= lsu_pkg::ls_idle;  // abandon without completion
    end else if (accept) begin
      state <= lsu_pkg::ls_busy;  // refill on the completing edge too
    end else if (complete) begin
      state <= lsu_pkg::ls_idle;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      dren_q       <= req.dren;
      dwen_q       <= req.dwen;
      wen_q        <= req.wen;
      reg_rd_q     <= req.reg_rd;
      load_type_q  <= req.load_type;
      store_data_q <= req.store_data;
      tag_q        <= req.tag;
      address_q    <= address;
      byte_en_q    <= byte_en;
      mal_q        <= mal_addr;
    end
  end

  // bus side held stable while dbus_busy is high
  always_comb begin
    dbus.ren     = full & dren_q & ~mal_q & ~flush;
    dbus.wen     = full & dwen_q & ~mal_q & ~flush;
    dbus.addr    = address_q;
    dbus.byte_en = byte_en_q;
    case (load_type_q)
      lsu_pkg::lb,
      lsu_pkg::lbu: dbus.wdata = {4{store_data_q[7:0]}};   // byte in every lane
      lsu_pkg::lh,
      lsu_pkg::lhu: dbus.wdata = {2{store_data_q[15:0]}};  // half in both halves
      default:      dbus.wdata = store_data_q;
    endcase
  end

  assign lat_load_type = load_type_q;
  assign lat_byte_en   = byte_en_q;

  // completion report as a single cycle pulse
  always_comb begin
    resp.done     = complete & ~flush;
    resp.wen      = wen_q & ~mal_q;
    resp.reg_rd   = reg_rd_q;
    resp.wdata    = (dren_q & ~mal_q) ? ext_data : '0;  // zero when misaligned
    resp.tag      = tag_q;
    resp.mal_addr = mal_q;
    resp.addr     = address_q;
  end

endmodule

`default_nettype wire

/* hdl/dmem_extender.sv */
// dmem_extender: picks the addressed byte or half of a read word and extends it
`timescale 1ns/100ps
`default_nettype none

module dmem_extender (
  input  wire logic [lsu_pkg::XLEN-1:0] dmem_in,   // little endian bus word
  input  wire lsu_pkg::load_t           load_type,
  input  wire logic [3:0]               byte_en,
  output logic      [lsu_pkg::XLEN-1:0] ext_out
);

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  // byte lane from the one-hot enable
  always_comb begin
    case (byte_en)
      4'b0001: sel_byte = dmem_in[7:0];
      4'b0010: sel_byte = dmem_in[15:8];
      4'b0100: sel_byte = dmem_in[23:16];
      4'b1000: sel_byte = dmem_in[31:24];
      default: sel_byte = 8'h00;
    endcase
  end

  // upper half when lanes 2 and 3 are enabled
  always_comb begin
    if (byte_en == 4'b1100) begin
      sel_half = dmem_in[31:16];
    end else begin
      sel_half = dmem_in[15:0];
    end
  end

  always_comb begin
    case (load_type)
      lsu_pkg::lb:  ext_out = {{24{sel_byte[7]}}, sel_byte};   // sign
      lsu_pkg::lbu: ext_out = {24'h000000, sel_byte};          // zero
      lsu_pkg::lh:  ext_out = {{16{sel_half[15]}}, sel_half};
      lsu_pkg::lhu: ext_out = {16'h0000, sel_half};
      lsu_pkg::lw:  ext_out = dmem_in;                         // unchanged
      default:      ext_out = dmem_in;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/agu.sv */
// agu: address generation with lane mask and alignment check
`timescale 1ns/100ps
`default_nettype none

module agu (
  input  wire logic [lsu_pkg::XLEN-1:0] port_a,     // base register
  input  wire logic [lsu_pkg::XLEN-1:0] port_b,     // immediate offset
  input  wire lsu_pkg::load_t           load_type,
  output logic      [lsu_pkg::XLEN-1:0] address,
  output logic      [3:0]               byte_en,
  output logic                          mal_addr
);

  logic [1:0] offs;  // lane offset inside the word

  assign address = port_a + port_b;
  assign offs    = address[1:0];

  always_comb begin
    byte_en  = 4'b1111;
    mal_addr = 1'b0;
    case (load_type)
      lsu_pkg::lb,
      lsu_pkg::lbu: begin
        byte_en  = 4'b0001 << offs;  // any lane is legal
        mal_addr = 1'b0;
      end
      lsu_pkg::lh,
      lsu_pkg::lhu: begin
        byte_en  = offs[1] ? 4'b1100 : 4'b0011;
        mal_addr = offs[0];          // odd half address
      end
      lsu_pkg::lw: begin
        byte_en  = 4'b1111;
        mal_addr = |offs;            // word needs both low bits clear
      end
      default: begin
        byte_en  = 4'b1111;
        mal_addr = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/lsu_pkg.sv */
// lsu_pkg: shared widths, enums and packed structs of the load/store unit
`default_nettype none

package lsu_pkg;

  localparam int XLEN  = 32;  // data and address width
  localparam int REG_W = 5;   // register index
  localparam int TAG_W = 3;   // completion buffer index

  // access size and extension; stores reuse lb/lh/lw for size only
  typedef enum logic [2:0] {
    lb,
    lh,
    lw,
    lbu,
    lhu
  } load_t;

  // memory latch occupancy
  typedef enum logic {
    ls_idle,
    ls_busy
  } lsu_state_t;

  // issue stage request
  typedef struct packed {
    logic              valid;
    logic              dren;        // memory read
    logic              dwen;        // memory write
    logic              wen;         // register writeback
    logic [REG_W-1:0]  reg_rd;
    load_t             load_type;
    logic [XLEN-1:0]   port_a;      // base
    logic [XLEN-1:0]   port_b;      // offset
    logic [XLEN-1:0]   store_data;
    logic [TAG_W-1:0]  tag;
  } ls_req_t;

  // completion report to the completion buffer
  typedef struct packed {
    logic              done;
    logic              wen;
    logic [REG_W-1:0]  reg_rd;
    logic [XLEN-1:0]   wdata;       // extended load data
    logic [TAG_W-1:0]  tag;
    logic              mal_addr;
    logic [XLEN-1:0]   addr;
  } ls_resp_t;

  // simple data bus, little endian
  typedef struct packed {
    logic              ren;
    logic              wen;
    logic [XLEN-1:0]   addr;
    logic [3:0]        byte_en;
    logic [XLEN-1:0]   wdata;
  } dbus_req_t;

endpackage

`default_nettype wire
